// File: rvCoreCfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// datapath width, RV64
`define XLEN 64

// integer register file
`define REG_COUNT 32
`define REG_IDX_W 5

// first fetch address
`define RESET_PC 64'h0000_0000_0000_0000

`endif

// File: rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        AUIPC  = 7'b0010111,
        LUI    = 7'b0110111,
        JAL    = 7'b1101111,
        STORE  = 7'b0100011,
        SYSTEM = 7'b1110011
    } opcodeT;

    // store funct3 values
    typedef enum logic [2:0] {
        ST_BYTE   = 3'b000,
        ST_HALF   = 3'b001,
        ST_WORD   = 3'b010,
        ST_DOUBLE = 3'b011
    } storeWidthT;

    localparam logic [2:0] F3_ADD  = 3'b000; // add, addi, ecall/ebreak group
    localparam logic [6:0] F7_BASE = 7'b0000000;

endpackage

`default_nettype wire

// File: rvCtrlPkg.sv
`default_nettype none

package rvCtrlPkg;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_PASS_B = 4'd1 // lui
    } aluOpT;

    typedef enum logic [1:0] {
        WB_ALU = 2'b00,
        WB_PC4 = 2'b10 // link address
    } wbSelT;

    typedef enum logic {
        NPC_SEQ  = 1'b0,
        NPC_JUMP = 1'b1
    } npcSelT;

endpackage

`default_nettype wire

// File: ctrlBus.sv
`timescale 1ns/1ns
`default_nettype none

interface ctrlBus import rvCtrlPkg::*; ();

    aluOpT       aluOp;
    logic        selA;      // 1 rs1, 0 pc
    logic        selB;      // 1 rs2, 0 imm
    logic        writeRd;
    npcSelT      npcSel;
    wbSelT       wbSel;
    logic [7:0]  storeMask; // bit 0 is lowest byte
    logic        storeEn;

    modport decoder (
        output aluOp, selA, selB, writeRd, npcSel, wbSel, storeMask, storeEn
    );

    modport execute (
        input aluOp, selA, selB, writeRd, npcSel, wbSel, storeMask, storeEn
    );

endinterface

`default_nettype wire

// File: immGen.sv
`timescale 1ns/1ns
`default_nettype none
`include "rvCoreCfg.svh"

module immGen import rvIsaPkg::*; (
    input  wire logic [31:0]       inst,
    output logic      [`XLEN-1:0]  imm
);

    opcodeT opcode;

    assign opcode = opcodeT'(inst[6:0]);

    always_comb
    begin
        case (opcode)
            OP_IMM, SYSTEM:
            begin
                imm = {{(`XLEN-12){inst[31]}}, inst[31:20]}; // I
            end
            STORE:
            begin
                imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]}; // S
            end
            LUI, AUIPC:
            begin
                imm = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0}; // U
            end
            JAL:
            begin
                // J format, bit 0 always zero
                imm = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12],
                       inst[20], inst[30:21], 1'b0};
            end
            default:
            begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: instDecoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "rvCoreCfg.svh"

module instDecoder import rvIsaPkg::*, rvCtrlPkg::*; (
    input  wire logic [31:0]      inst,
    input  wire logic [`XLEN-1:0] imm,
    ctrlBus.decoder               ctrl,
    output logic                  isBreak
);

    opcodeT     opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcodeT'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // ebreak is SYSTEM, funct3 0, imm 1
    assign isBreak = (opcode == SYSTEM) && (funct3 == F3_ADD) && (imm == `XLEN'(1));

    always_comb
    begin
        // defaults give a no-op
        ctrl.aluOp     = ALU_ADD;
        ctrl.selA      = 1'b1;
        ctrl.selB      = 1'b0;
        ctrl.writeRd   = 1'b0;
        ctrl.npcSel    = NPC_SEQ;
        ctrl.wbSel     = WB_ALU;
        ctrl.storeMask = 8'h00;

        case (opcode)
            OP:
            begin
                if (funct3 == F3_ADD && funct7 == F7_BASE) // add
                begin
                    ctrl.selB    = 1'b1;
                    ctrl.writeRd = 1'b1;
                end
            end
            OP_IMM:
            begin
                if (funct3 == F3_ADD) // addi
                begin
                    ctrl.writeRd = 1'b1;
                end
            end
            AUIPC:
            begin
                ctrl.selA    = 1'b0; // pc + imm
                ctrl.writeRd = 1'b1;
            end
            LUI:
            begin
                ctrl.aluOp   = ALU_PASS_B;
                ctrl.writeRd = 1'b1;
            end
            JAL:
            begin
                ctrl.writeRd = 1'b1;
                ctrl.npcSel  = NPC_JUMP;
                ctrl.wbSel   = WB_PC4;
            end
            STORE:
            begin
                // address is always rs1 + imm
                case (storeWidthT'(funct3))
                    ST_BYTE:   ctrl.storeMask = 8'h01;
                    ST_HALF:   ctrl.storeMask = 8'h03;
                    ST_WORD:   ctrl.storeMask = 8'h0F;
                    ST_DOUBLE: ctrl.storeMask = 8'hFF;
                    default:   ctrl.storeMask = 8'h00;
                endcase
            end
            default:
            begin
            end
        endcase

        ctrl.storeEn = |ctrl.storeMask;
    end

    // a store never writes back, whatever the opcode table says
    always_comb
    begin
        assert (!(ctrl.storeEn && ctrl.writeRd))
            else $error("store and register write decoded together");
    end

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/1ns
`default_nettype none
`include "rvCoreCfg.svh"

module regFile (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [`REG_IDX_W-1:0] rs1Idx,
    input  wire logic [`REG_IDX_W-1:0] rs2Idx,
    output logic      [`XLEN-1:0]      rs1Data,
    output logic      [`XLEN-1:0]      rs2Data,
    input  wire logic                  wrEn,
    input  wire logic [`REG_IDX_W-1:0] wrIdx,
    input  wire logic [`XLEN-1:0]      wrData
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wrEn && wrIdx != '0) // x0 is read-only
        begin
            regs[wrIdx] <= wrData;
        end
    end

    assign rs1Data = regs[rs1Idx]; // async read
    assign rs2Data = regs[rs2Idx];

    x0Zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
        else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

// File: rvExecute.sv
`timescale 1ns/1ns
`default_nettype none
`include "rvCoreCfg.svh"

module rvExecute import rvCtrlPkg::*; (
    input  wire logic [`XLEN-1:0] pc,
    input  wire logic [`XLEN-1:0] imm,
    input  wire logic [`XLEN-1:0] rs1Data,
    input  wire logic [`XLEN-1:0] rs2Data,
    ctrlBus.execute               ctrl,
    output logic      [`XLEN-1:0] nextPc,
    output logic      [`XLEN-1:0] rdData,
    output logic      [`XLEN-1:0] storeAddr,
    output logic      [`XLEN-1:0] storeData
);

    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluRes;
    logic [`XLEN-1:0] pcPlus4;

    assign opA = ctrl.selA ? rs1Data : pc;
    assign opB = ctrl.selB ? rs2Data : imm;

    always_comb
    begin
        case (ctrl.aluOp)
            ALU_ADD:    aluRes = opA + opB;
            ALU_PASS_B: aluRes = opB;
            default:    aluRes = '0;
        endcase
    end

    assign pcPlus4 = pc + `XLEN'(4);
    assign nextPc  = (ctrl.npcSel == NPC_JUMP) ? pc + imm : pcPlus4; // jal target

    always_comb
    begin
        case (ctrl.wbSel)
            WB_PC4:  rdData = pcPlus4; // link value
            default: rdData = aluRes;
        endcase
    end

    assign storeAddr = aluRes; // rs1 + imm on stores
    assign storeData = rs2Data;

endmodule

`default_nettype wire

// File: rvCore.sv
`timescale 1ns/1ns
`default_nettype none
`include "rvCoreCfg.svh"

module rvCore (
    input  wire logic             clk,
    input  wire logic             rst,
    output logic      [`XLEN-1:0] instAddr,
    input  wire logic [31:0]      inst,
    output logic                  storeValid,
    output logic      [`XLEN-1:0] storeAddr,
    output logic      [`XLEN-1:0] storeData,
    output logic      [7:0]       storeMask,
    output logic                  halted
);

    logic [`XLEN-1:0]      pc;
    logic [`XLEN-1:0]      nextPc;
    logic [`XLEN-1:0]      imm;
    logic [`XLEN-1:0]      rs1Data;
    logic [`XLEN-1:0]      rs2Data;
    logic [`XLEN-1:0]      rdData;
    logic [`REG_IDX_W-1:0] rs1Idx;
    logic [`REG_IDX_W-1:0] rs2Idx;
    logic [`REG_IDX_W-1:0] rdIdx;
    logic                  isBreak;
    logic                  active;
    logic                  regWrEn;

    ctrlBus ctrl ();

    assign rs1Idx = inst[19:15];
    assign rs2Idx = inst[24:20];
    assign rdIdx  = inst[11:7];

    assign active     = !rst && !halted; // no side effects in reset or halt
    assign regWrEn    = ctrl.writeRd && active;
    assign storeValid = ctrl.storeEn && active;
    assign storeMask  = ctrl.storeMask;
    assign instAddr   = pc;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc     <= `RESET_PC;
            halted <= 1'b0;
        end
        else if (!halted)
        begin
            if (isBreak)
                halted <= 1'b1; // pc stays on the ebreak
            else
                pc <= nextPc;
        end
    end

    immGen i_immGen (
        .inst (inst),
        .imm  (imm)
    );

    instDecoder i_instDecoder (
        .inst    (inst),
        .imm     (imm),
        .ctrl    (ctrl.decoder),
        .isBreak (isBreak)
    );

    regFile i_regFile (
        .clk     (clk),
        .rst     (rst),
        .rs1Idx  (rs1Idx),
        .rs2Idx  (rs2Idx),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wrEn    (regWrEn),
        .wrIdx   (rdIdx),
        .wrData  (rdData)
    );

    rvExecute i_rvExecute (
        .pc        (pc),
        .imm       (imm),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .ctrl      (ctrl.execute),
        .nextPc    (nextPc),
        .rdData    (rdData),
        .storeAddr (storeAddr),
        .storeData (storeData)
    );

    haltHoldsPc: assert property (@(posedge clk) disable iff (rst) halted |=> $stable(pc))
        else $error("pc moved while halted");

endmodule

`default_nettype wire

// File: tb_rvCore.sv
`timescale 1ns/1ns
`default_nettype none
`include "rvCoreCfg.svh"

module tb_rvCore import rvIsaPkg::*;;

    localparam int progLen    = 19;
    localparam int cycleLimit = 2 * progLen + 20;

    logic             clk;
    logic             rst;
    logic [`XLEN-1:0] instAddr;
    logic [31:0]      inst;
    logic             storeValid;
    logic [`XLEN-1:0] storeAddr;
    logic [`XLEN-1:0] storeData;
    logic [7:0]       storeMask;
    logic             halted;

    logic [31:0]      rom [64];
    logic [`XLEN-1:0] modelRegs [32];
    logic [`XLEN-1:0] modelPc;
    logic             modelHalted;
    logic [`XLEN-1:0] expPc;
    logic             expValid;
    logic [`XLEN-1:0] expAddr;
    logic [`XLEN-1:0] expData;
    logic [7:0]       expMask;
    logic             expHalted;
    int               seed = 98;
    int               cycleCount;
    int               haltCycles;
    int               pcErrors;
    int               storeErrors;
    int               haltErrors;

    rvCore i_rvCore (
        .clk        (clk),
        .rst        (rst),
        .instAddr   (instAddr),
        .inst       (inst),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData),
        .storeMask  (storeMask),
        .halted     (halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] addiInst(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] addInst(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, OP};
    endfunction

    function automatic logic [31:0] upperInst(input opcodeT opc, input logic [4:0] rd,
                                              input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] jalInst(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
    endfunction

    function automatic logic [31:0] storeInst(input storeWidthT w, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, w, imm[4:0], STORE};
    endfunction

    // a store writes 2**funct3 bytes from the bottom
    function automatic logic [7:0] byteMask(input logic [2:0] f3);
        return 8'((16'd1 << (4'd1 << f3)) - 16'd1);
    endfunction

    task automatic loadProgram();
        logic [11:0] immA;
        logic [11:0] immB;
        logic [11:0] immC;
        logic [11:0] offS;
        logic [19:0] upA;
        logic [19:0] upB;
        for (int i = 0; i < 64; i++)
        begin
            rom[i] = addiInst(5'd0, 5'd0, 12'(i)); // no-op fill, differs per word
        end
        immA = 12'($random(seed));
        immB = 12'($random(seed));
        immC = 12'($random(seed));
        offS = 12'($random(seed));
        upA  = 20'($random(seed));
        upB  = 20'($random(seed));
        rom[0]  = addiInst(5'd1, 5'd0, immA);
        rom[1]  = addiInst(5'd2, 5'd1, immB);
        rom[2]  = addInst(5'd3, 5'd1, 5'd2);
        rom[3]  = storeInst(ST_DOUBLE, 5'd3, 5'd2, offS);
        rom[4]  = addiInst(5'd0, 5'd1, immC);        // discarded write
        rom[5]  = storeInst(ST_DOUBLE, 5'd0, 5'd1, 12'd8);
        rom[6]  = upperInst(LUI, 5'd4, upA);
        rom[7]  = upperInst(AUIPC, 5'd5, upB);
        rom[8]  = storeInst(ST_DOUBLE, 5'd4, 5'd0, 12'd16);
        rom[9]  = storeInst(ST_DOUBLE, 5'd5, 5'd0, 12'd24);
        rom[10] = jalInst(5'd6, 21'd8);               // hops over word 11
        rom[11] = storeInst(ST_DOUBLE, 5'd1, 5'd0, 12'd0);
        rom[12] = storeInst(ST_DOUBLE, 5'd6, 5'd0, 12'd32);
        rom[13] = storeInst(ST_BYTE, 5'd3, 5'd2, 12'd1);
        rom[14] = storeInst(ST_HALF, 5'd3, 5'd2, 12'd2);
        rom[15] = storeInst(ST_WORD, 5'd3, 5'd2, 12'd4);
        rom[16] = addInst(5'd7, 5'd3, 5'd4);
        rom[17] = storeInst(ST_DOUBLE, 5'd7, 5'd1, 12'd40);
        rom[18] = {12'd1, 5'd0, 3'b000, 5'd0, SYSTEM}; // ebreak
    endtask

    // drive the word at instAddr, set expectations from the model PC, then advance the model
    task automatic presentAndStep();
        logic [31:0]      w;
        logic [`XLEN-1:0] rs1v;
        logic [`XLEN-1:0] rs2v;
        logic [`XLEN-1:0] immI;
        logic [`XLEN-1:0] immS;
        logic [`XLEN-1:0] immU;
        logic [`XLEN-1:0] immJ;
        logic [`XLEN-1:0] rdVal;
        logic [`XLEN-1:0] npc;
        logic             wr;
        w     = rom[modelPc[7:2]];
        inst  = rom[instAddr[7:2]]; // fetch answers the core's own address
        rs1v  = modelRegs[w[19:15]];
        rs2v  = modelRegs[w[24:20]];
        immI  = {{52{w[31]}}, w[31:20]};
        immS  = {{52{w[31]}}, w[31:25], w[11:7]};
        immU  = {{32{w[31]}}, w[31:12], 12'b0};
        immJ  = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        wr    = 1'b0;
        rdVal = '0;
        npc   = modelPc + 64'd4;
        expPc     = modelPc;
        expValid  = 1'b0;
        expAddr   = '0;
        expData   = '0;
        expMask   = 8'h00;
        expHalted = modelHalted;
        if (modelHalted)
        begin
            npc = modelPc; // frozen until reset
        end
        else
        begin
            case (opcodeT'(w[6:0]))
                OP_IMM:
                begin
                    wr    = (w[14:12] == 3'b000);
                    rdVal = rs1v + immI;
                end
                OP:
                begin
                    wr    = (w[14:12] == 3'b000) && (w[31:25] == 7'b0000000);
                    rdVal = rs1v + rs2v;
                end
                LUI:
                begin
                    wr    = 1'b1;
                    rdVal = immU;
                end
                AUIPC:
                begin
                    wr    = 1'b1;
                    rdVal = modelPc + immU;
                end
                JAL:
                begin
                    wr    = 1'b1;
                    rdVal = modelPc + 64'd4; // link
                    npc   = modelPc + immJ;
                end
                STORE:
                begin
                    if (w[14:12] <= 3'b011)
                    begin
                        expValid = 1'b1;
                        expAddr  = rs1v + immS;
                        expData  = rs2v;
                        expMask  = byteMask(w[14:12]);
                    end
                end
                SYSTEM:
                begin
                    if (w[14:12] == 3'b000 && immI == 64'd1)
                    begin
                        modelHalted = 1'b1;
                        npc         = modelPc;
                    end
                end
                default:
                begin
                end
            endcase
        end
        if (wr && w[11:7] != 5'd0)
        begin
            modelRegs[w[11:7]] = rdVal;
        end
        modelPc = npc;
    endtask

    pcFollows: assert property (@(posedge clk) disable iff (rst) instAddr == expPc)
        else
        begin
            pcErrors++;
            $display("Error at %0t: instAddr %h, expected %h", $time,
                     $sampled(instAddr), expPc);
        end

    validFollows: assert property (@(posedge clk) disable iff (rst) storeValid == expValid)
        else
        begin
            storeErrors++;
            $display("Error at %0t: storeValid %b, expected %b", $time,
                     $sampled(storeValid), expValid);
        end

    storeContents: assert property (@(posedge clk) disable iff (rst)
        expValid |-> (storeAddr == expAddr && storeData == expData && storeMask == expMask))
        else
        begin
            storeErrors++;
            $display("Error at %0t: store %h/%h/%h, expected %h/%h/%h", $time,
                     $sampled(storeAddr), $sampled(storeData), $sampled(storeMask),
                     expAddr, expData, expMask);
        end

    haltFollows: assert property (@(posedge clk) disable iff (rst) halted == expHalted)
        else
        begin
            haltErrors++;
            $display("Error at %0t: halted %b, expected %b", $time,
                     $sampled(halted), expHalted);
        end

    initial
    begin
        cycleCount = 0;
        while (cycleCount < cycleLimit)
        begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the core did not reach the end of the program in %0d cycles",
                 cycleLimit);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial
    begin
        rst         = 1'b1;
        inst        = 32'h0000_0013; // addi x0, x0, 0
        pcErrors    = 0;
        storeErrors = 0;
        haltErrors  = 0;
        modelPc     = `RESET_PC;
        modelHalted = 1'b0;
        expPc       = `RESET_PC;
        expValid    = 1'b0;
        expAddr     = '0;
        expData     = '0;
        expMask     = 8'h00;
        expHalted   = 1'b0;
        for (int i = 0; i < 32; i++)
        begin
            modelRegs[i] = '0;
        end
        loadProgram();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst        = 1'b0;
        haltCycles = 0;
        while (haltCycles < 4) // a few cycles in halt to see the PC hold
        begin
            presentAndStep();
            if (modelHalted)
            begin
                haltCycles++;
            end
            @(negedge clk);
        end
        $display("errors: pc %0d, store %0d, halt %0d", pcErrors, storeErrors, haltErrors);
        if (pcErrors + storeErrors + haltErrors == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rvCore.f
+incdir+.
rvIsaPkg.sv
rvCtrlPkg.sv
ctrlBus.sv
immGen.sv
instDecoder.sv
regFile.sv
rvExecute.sv
rvCore.sv
tb_rvCore.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_rvCore -f rvCore.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1 ; cat sim.log 2>/dev/null
grep -q "SIMULATION PASSED" sim.log \
    && echo "run.sh: simulation reported success" \
    || { echo "run.sh: simulation did not report success"; exit 1; }
